/* design/cacheGeomPkg.sv */
package cacheGeomPkg;

	// ----------------------------------------
	// address and data widths
	// ----------------------------------------

	localparam int ADDR_BITS = 32;
	localparam int WORD_BITS = 32;

	// byte lanes inside a word, never decoded
	localparam int BYTE_OFFSET_BITS = 2;

	// ----------------------------------------
	// vector types
	// ----------------------------------------

	// byte address, split low to high into
	// byte offset, word offset, index, tag
	typedef logic [ADDR_BITS-1:0] addrT;

	typedef logic [WORD_BITS-1:0] wordT; // one data word

	// two ways, so a single bit
	// also marks the LRU way of a set
	typedef logic wayT;

endpackage

/* design/cacheCtrlPkg.sv */
package cacheCtrlPkg;

	// requester opcode
	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE,
		OP_INVALIDATE
	} cacheOpT;

	// controller FSM
	typedef enum logic [2:0] {
		S_IDLE,        // lookup, hits finish here
		S_WRITEBACK,   // dirty line out, one word per cycle
		S_REFILL_REQ,
		S_REFILL_WAIT,
		S_RESPOND      // replay as a hit
	} ctrlStateT;

endpackage

/* design/lineBeatCounter.sv */
`timescale 1ns/1ps

module lineBeatCounter #(
	parameter int LINE_WORDS = 8,
	localparam int COUNT_BITS = $clog2(LINE_WORDS)
) (
	input logic clk,
	input logic beatStart,
	input logic beatStep,
	output logic [COUNT_BITS-1:0] beatCount,
	output logic beatLast
);

	// word index of the current beat
	always_ff @(posedge clk) begin
		if (beatStart) begin
			beatCount <= '0;
		end else if (beatStep) begin
			beatCount <= beatCount + 1'b1;
		end
	end

	// final word of the line
	assign beatLast = (beatCount == COUNT_BITS'(LINE_WORDS - 1));

endmodule

/* design/tagStore.sv */
`timescale 1ns/1ps

module tagStore #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS = 8,
	localparam int TAG_BITS = cacheGeomPkg::ADDR_BITS - INDEX_BITS - $clog2(LINE_WORDS)
		- cacheGeomPkg::BYTE_OFFSET_BITS
) (
	input logic clk,
	input logic reset,
	input cacheGeomPkg::addrT addr,
	input logic [TAG_BITS-1:0] fillTag,
	input logic tagFill,
	input logic tagTouch,
	input logic tagSetDirty,
	input logic tagClean,
	input logic tagInvalidate,
	input cacheGeomPkg::wayT accessWay,
	output logic lookupHit,
	output cacheGeomPkg::wayT hitWay,
	output cacheGeomPkg::wayT victimWay,
	output logic victimDirty,
	output logic [TAG_BITS-1:0] victimTag
);
	import cacheGeomPkg::*;

	localparam int SETS = 2 ** INDEX_BITS;
	localparam int INDEX_LSB = BYTE_OFFSET_BITS + $clog2(LINE_WORDS);

	logic [TAG_BITS-1:0] tags [2][SETS];
	logic dirty [2][SETS];
	logic valid [2][SETS];
	wayT lru [SETS]; // least recently used way of the set

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] reqTag;
	logic [1:0] wayHit;

	assign index = addr[INDEX_LSB +: INDEX_BITS];
	assign reqTag = addr[ADDR_BITS-1 -: TAG_BITS];

	// ----------------------------------------
	// lookup and victim choice
	// ----------------------------------------

	assign wayHit[0] = valid[0][index] && (tags[0][index] == reqTag);
	assign wayHit[1] = valid[1][index] && (tags[1][index] == reqTag);
	assign lookupHit = |wayHit;
	assign hitWay = wayHit[1];

	always_comb begin
		if (lookupHit) begin
			victimWay = hitWay; // line leaving on invalidate
		end else if (!valid[0][index]) begin
			victimWay = 1'b0;
		end else if (!valid[1][index]) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lru[index];
		end
	end

	assign victimDirty = valid[victimWay][index] && dirty[victimWay][index];
	assign victimTag = tags[victimWay][index];

	// ----------------------------------------
	// updates
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (tagFill) begin
			tags[accessWay][index] <= fillTag;
			dirty[accessWay][index] <= 1'b0;
		end
		if (tagSetDirty) begin
			dirty[accessWay][index] <= 1'b1;
		end
		if (tagClean || tagInvalidate) begin
			dirty[accessWay][index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int s = 0; s < SETS; s++) begin
				valid[0][s] <= 1'b0;
				valid[1][s] <= 1'b0;
				lru[s] <= 1'b0;
			end
		end else begin
			if (tagFill) begin
				valid[accessWay][index] <= 1'b1;
			end
			if (tagInvalidate) begin
				valid[accessWay][index] <= 1'b0;
			end
			if (tagFill || tagTouch) begin
				lru[index] <= ~accessWay; // other way is now older
			end
		end
	end

endmodule

/* design/dataStore.sv */
`timescale 1ns/1ps

module dataStore #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS = 8,
	localparam int WORD_OFF_BITS = $clog2(LINE_WORDS)
) (
	input logic clk,
	input cacheGeomPkg::addrT addr,
	input cacheGeomPkg::wayT accessWay,
	input logic wordWrite,
	input cacheGeomPkg::wordT writeData,
	output cacheGeomPkg::wordT readData,
	input logic beatWrite,
	input logic [WORD_OFF_BITS-1:0] beatCount,
	input cacheGeomPkg::wordT memReadData,
	output cacheGeomPkg::wordT memWriteData
);
	import cacheGeomPkg::*;

	localparam int SETS = 2 ** INDEX_BITS;

	wordT words [2][SETS][LINE_WORDS];

	logic [INDEX_BITS-1:0] index;
	logic [WORD_OFF_BITS-1:0] wordOffset;

	assign wordOffset = addr[BYTE_OFFSET_BITS +: WORD_OFF_BITS];
	assign index = addr[BYTE_OFFSET_BITS + WORD_OFF_BITS +: INDEX_BITS];

	// ----------------------------------------
	// reads
	// ----------------------------------------

	// requester word
	assign readData = words[accessWay][index][wordOffset];

	// write-back beat word
	assign memWriteData = words[accessWay][index][beatCount];

	// ----------------------------------------
	// writes
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (wordWrite) begin
			words[accessWay][index][wordOffset] <= writeData;
		end
		if (beatWrite) begin
			words[accessWay][index][beatCount] <= memReadData; // refill beat
		end
	end

endmodule

/* design/cacheControl.sv */
`timescale 1ns/1ps

module cacheControl #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS = 8,
	localparam int WORD_OFF_BITS = $clog2(LINE_WORDS),
	localparam int TAG_BITS = cacheGeomPkg::ADDR_BITS - INDEX_BITS - WORD_OFF_BITS
		- cacheGeomPkg::BYTE_OFFSET_BITS
) (
	input logic clk,
	input logic reset,
	input cacheCtrlPkg::cacheOpT op,
	input cacheGeomPkg::addrT addr,
	output logic done,
	output logic hit,
	output logic memReadReq,
	output cacheGeomPkg::addrT memReadAddr,
	input logic memReadValid,
	output logic memWriteValid,
	output cacheGeomPkg::addrT memWriteAddr,
	input logic lookupHit,
	input cacheGeomPkg::wayT hitWay,
	input cacheGeomPkg::wayT victimWay,
	input logic victimDirty,
	input logic [TAG_BITS-1:0] victimTag,
	output logic [TAG_BITS-1:0] fillTag,
	output logic tagFill,
	output logic tagTouch,
	output logic tagSetDirty,
	output logic tagClean,
	output logic tagInvalidate,
	output cacheGeomPkg::wayT accessWay,
	output logic wordWrite,
	output logic beatWrite,
	output logic beatStart,
	output logic beatStep,
	input logic [WORD_OFF_BITS-1:0] beatCount,
	input logic beatLast
);
	import cacheGeomPkg::*;
	import cacheCtrlPkg::*;

	localparam int INDEX_LSB = BYTE_OFFSET_BITS + WORD_OFF_BITS;

	ctrlStateT state;
	ctrlStateT nextState;
	wayT targetWay; // way picked at the first lookup
	logic complete;
	logic isWrite;
	logic isInval;
	logic needWriteback;
	logic [INDEX_BITS-1:0] index;

	assign isWrite = (op == OP_WRITE);
	assign isInval = (op == OP_INVALIDATE);
	assign index = addr[INDEX_LSB +: INDEX_BITS];
	assign fillTag = addr[ADDR_BITS-1 -: TAG_BITS];

	// a miss only writes back a dirty victim, an invalidate only a dirty hit
	assign needWriteback = victimDirty && (lookupHit || !isInval);

	// ----------------------------------------
	// memory addresses
	// ----------------------------------------

	assign memReadAddr = {fillTag, index, {INDEX_LSB{1'b0}}};
	assign memWriteAddr = {victimTag, index, beatCount, {BYTE_OFFSET_BITS{1'b0}}};

	// ----------------------------------------
	// next state and strobes
	// ----------------------------------------

	always_comb begin
		nextState = state;
		accessWay = targetWay;
		complete = 1'b0;
		memReadReq = 1'b0;
		memWriteValid = 1'b0;
		tagFill = 1'b0;
		tagTouch = 1'b0;
		tagSetDirty = 1'b0;
		tagClean = 1'b0;
		tagInvalidate = 1'b0;
		wordWrite = 1'b0;
		beatWrite = 1'b0;
		beatStart = 1'b0;
		beatStep = 1'b0;

		case (state)
			S_IDLE: begin
				accessWay = hitWay;
				if (op != OP_NONE) begin
					if (lookupHit && !isInval) begin
						tagTouch = 1'b1;
						tagSetDirty = isWrite;
						wordWrite = isWrite;
						complete = 1'b1;
					end else if (needWriteback) begin
						beatStart = 1'b1; // count is 0 on first beat
						nextState = S_WRITEBACK;
					end else if (isInval) begin
						tagInvalidate = lookupHit; // absent line, nothing to do
						complete = 1'b1;
					end else begin
						nextState = S_REFILL_REQ;
					end
				end
			end

			S_WRITEBACK: begin
				memWriteValid = 1'b1;
				beatStep = 1'b1;
				if (beatLast) begin
					if (isInval) begin
						tagInvalidate = 1'b1;
						complete = 1'b1;
						nextState = S_IDLE;
					end else begin
						tagClean = 1'b1;
						nextState = S_REFILL_REQ;
					end
				end
			end

			S_REFILL_REQ: begin
				memReadReq = 1'b1;
				beatStart = 1'b1;
				nextState = S_REFILL_WAIT;
			end

			S_REFILL_WAIT: begin
				beatWrite = memReadValid;
				beatStep = memReadValid;
				if (memReadValid && beatLast) begin
					tagFill = 1'b1; // new tag after the last word
					nextState = S_RESPOND;
				end
			end

			S_RESPOND: begin
				tagTouch = 1'b1;
				tagSetDirty = isWrite;
				wordWrite = isWrite;
				complete = 1'b1;
				nextState = S_IDLE;
			end

			default: begin
				nextState = S_IDLE;
			end
		endcase
	end

	// ----------------------------------------
	// registers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			done <= 1'b0;
			hit <= 1'b0;
		end else begin
			state <= nextState;
			done <= complete;
			if (state == S_IDLE && op != OP_NONE) begin
				hit <= lookupHit; // first lookup only
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && op != OP_NONE) begin
			targetWay <= victimWay;
		end
	end

endmodule

/* design/setAssocCache.sv */
`timescale 1ns/1ps

module setAssocCache #(
	parameter int INDEX_BITS = 4,
	parameter int LINE_WORDS = 8
) (
	input logic clk,
	input logic reset,
	input cacheCtrlPkg::cacheOpT op,
	input cacheGeomPkg::addrT addr,
	input cacheGeomPkg::wordT writeData,
	output cacheGeomPkg::wordT readData,
	output logic done,
	output logic hit,
	output logic memReadReq,
	output cacheGeomPkg::addrT memReadAddr,
	input logic memReadValid,
	input cacheGeomPkg::wordT memReadData,
	output logic memWriteValid,
	output cacheGeomPkg::addrT memWriteAddr,
	output cacheGeomPkg::wordT memWriteData
);
	import cacheGeomPkg::*;

	localparam int WORD_OFF_BITS = $clog2(LINE_WORDS);
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - WORD_OFF_BITS - BYTE_OFFSET_BITS;

	// tag store results
	logic lookupHit;
	wayT hitWay;
	wayT victimWay;
	logic victimDirty;
	logic [TAG_BITS-1:0] victimTag;

	// tag store updates
	logic [TAG_BITS-1:0] fillTag;
	logic tagFill;
	logic tagTouch;
	logic tagSetDirty;
	logic tagClean;
	logic tagInvalidate;
	wayT accessWay;

	// data store and beat counter
	logic wordWrite;
	logic beatWrite;
	logic beatStart;
	logic beatStep;
	logic [WORD_OFF_BITS-1:0] beatCount;
	logic beatLast;

	cacheControl #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS(LINE_WORDS)) control0 (
		.clk(clk), .reset(reset), .op(op), .addr(addr), .done(done), .hit(hit),
		.memReadReq(memReadReq), .memReadAddr(memReadAddr), .memReadValid(memReadValid),
		.memWriteValid(memWriteValid), .memWriteAddr(memWriteAddr),
		.lookupHit(lookupHit), .hitWay(hitWay), .victimWay(victimWay),
		.victimDirty(victimDirty), .victimTag(victimTag), .fillTag(fillTag),
		.tagFill(tagFill), .tagTouch(tagTouch), .tagSetDirty(tagSetDirty),
		.tagClean(tagClean), .tagInvalidate(tagInvalidate), .accessWay(accessWay),
		.wordWrite(wordWrite), .beatWrite(beatWrite), .beatStart(beatStart),
		.beatStep(beatStep), .beatCount(beatCount), .beatLast(beatLast)
	);

	tagStore #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS(LINE_WORDS)) tags0 (
		.clk(clk), .reset(reset), .addr(addr), .fillTag(fillTag),
		.tagFill(tagFill), .tagTouch(tagTouch), .tagSetDirty(tagSetDirty),
		.tagClean(tagClean), .tagInvalidate(tagInvalidate), .accessWay(accessWay),
		.lookupHit(lookupHit), .hitWay(hitWay), .victimWay(victimWay),
		.victimDirty(victimDirty), .victimTag(victimTag)
	);

	dataStore #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS(LINE_WORDS)) data0 (
		.clk(clk), .addr(addr), .accessWay(accessWay), .wordWrite(wordWrite),
		.writeData(writeData), .readData(readData), .beatWrite(beatWrite),
		.beatCount(beatCount), .memReadData(memReadData), .memWriteData(memWriteData)
	);

	lineBeatCounter #(.LINE_WORDS(LINE_WORDS)) beats0 (
		.clk(clk),
		.beatStart(beatStart),
		.beatStep(beatStep),
		.beatCount(beatCount),
		.beatLast(beatLast)
	);

endmodule

/* test/setAssocCache_sva.sv */
`timescale 1ns/1ps

module setAssocCacheSva #(
	parameter int LINE_WORDS = 8
) (
	input logic clk,
	input logic reset,
	input logic done,
	input logic memReadReq,
	input logic memWriteValid
);

	int runLength; // consecutive write-back beats so far
	int failCount = 0; // failed assertions so far

	always_ff @(posedge clk) begin
		if (reset || !memWriteValid) begin
			runLength <= 0;
		end else begin
			runLength <= runLength + 1;
		end
	end

	// ----------------------------------------
	// requester side
	// ----------------------------------------

	doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
		else begin
			failCount++;
			$error("done stayed high for more than one cycle");
		end

	quietAfterReset: assert property (@(posedge clk)
		reset |=> !done && !memReadReq && !memWriteValid)
		else begin
			failCount++;
			$error("done or memory strobe high right after reset");
		end

	// ----------------------------------------
	// memory side
	// ----------------------------------------

	noReadDuringWrite: assert property (@(posedge clk) disable iff (reset)
		!(memReadReq && memWriteValid))
		else begin
			failCount++;
			$error("refill request during a write-back beat");
		end

	// a burst never runs past one line
	writebackNoOverrun: assert property (@(posedge clk) disable iff (reset)
		memWriteValid |-> runLength < LINE_WORDS)
		else begin
			failCount++;
			$error("write-back burst longer than one line");
		end

	writebackFullLine: assert property (@(posedge clk) disable iff (reset)
		!memWriteValid && runLength != 0 |-> runLength == LINE_WORDS)
		else begin
			failCount++;
			$error("write-back burst ended before the whole line");
		end

endmodule

/* test/setAssocCacheTb.sv */
`timescale 1ns/1ps

module setAssocCacheTb;
	import cacheGeomPkg::*;
	import cacheCtrlPkg::*;

	localparam int INDEX_BITS = 4;
	localparam int LINE_WORDS = 8;
	localparam int MEM_ADDR_BITS = 10; // word address bits of the memory model
	localparam int MEM_WORDS = 2 ** MEM_ADDR_BITS;
	localparam int REQUESTS = 32;
	localparam int WATCHDOG_CYCLES = REQUESTS * (2 * LINE_WORDS + 10) + 100;

	logic clk;
	logic reset;
	cacheOpT op;
	addrT addr;
	wordT writeData;
	wordT readData;
	logic done;
	logic hit;
	logic memReadReq;
	addrT memReadAddr;
	logic memReadValid;
	wordT memReadData;
	logic memWriteValid;
	addrT memWriteAddr;
	wordT memWriteData;

	wordT memWords [MEM_WORDS];
	wordT shadow [MEM_WORDS]; // latest requester value per word
	logic [31:0] rngState;

	string testName;
	int checkCount;
	int errorCount;
	int readReqCount;
	addrT lastReadAddr;
	addrT beatAddrs [$]; // write-back beats seen by the memory
	wordT beatData [$];
	wordT gotData;
	logic gotHit;

	setAssocCache #(.INDEX_BITS(INDEX_BITS), .LINE_WORDS(LINE_WORDS)) dut0 (
		.clk(clk), .reset(reset), .op(op), .addr(addr), .writeData(writeData),
		.readData(readData), .done(done), .hit(hit), .memReadReq(memReadReq),
		.memReadAddr(memReadAddr), .memReadValid(memReadValid), .memReadData(memReadData),
		.memWriteValid(memWriteValid), .memWriteAddr(memWriteAddr),
		.memWriteData(memWriteData)
	);

	bind setAssocCache setAssocCacheSva #(.LINE_WORDS(LINE_WORDS)) sva0 (
		.clk(clk), .reset(reset), .done(done), .memReadReq(memReadReq),
		.memWriteValid(memWriteValid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	function automatic addrT lineAddr(int tag, int set, int word);
		return addrT'(((tag * (2 ** INDEX_BITS) + set) * LINE_WORDS + word) * 4);
	endfunction

	function automatic int wordIndex(addrT a);
		return int'(a[2 +: MEM_ADDR_BITS]);
	endfunction

	// ----------------------------------------
	// memory model
	// ----------------------------------------

	// fill, then store write-back beats
	initial begin
		rngState = 32'd46228;
		for (int i = 0; i < MEM_WORDS; i++) begin
			memWords[i] = nextRandom() ^ wordT'(i);
			shadow[i] = memWords[i];
		end
		forever begin
			@(negedge clk);
			if (memWriteValid) begin
				memWords[wordIndex(memWriteAddr)] = memWriteData;
				beatAddrs.push_back(memWriteAddr);
				beatData.push_back(memWriteData);
			end
		end
	end

	// refill beats in word order with 0 to 2 idle cycles before each
	initial begin
		int base;
		int gap;
		memReadValid = 1'b0;
		memReadData = '0;
		forever begin
			@(negedge clk);
			if (memReadReq) begin
				readReqCount++;
				lastReadAddr = memReadAddr;
				base = wordIndex(memReadAddr);
				for (int k = 0; k < LINE_WORDS; k++) begin
					gap = int'(nextRandom() % 3);
					repeat (gap) begin
						@(negedge clk);
						memReadValid = 1'b0;
					end
					@(negedge clk);
					memReadValid = 1'b1;
					memReadData = memWords[base + k];
				end
				@(negedge clk);
				memReadValid = 1'b0;
			end
		end
	end

	// ----------------------------------------
	// requests and checks
	// ----------------------------------------

	task automatic doRequest(cacheOpT reqOp, addrT reqAddr, wordT reqData);
		@(negedge clk);
		op = reqOp;
		addr = reqAddr;
		writeData = reqData;
		do begin
			@(negedge clk);
		end while (!done);
		gotData = readData;
		gotHit = hit;
		op = OP_NONE;
	endtask

	task automatic expectEqual(string what, logic [31:0] expected, logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("ERROR %s %s: expected %h, got %h", testName, what, expected, actual);
		end
	endtask

	task automatic readCheck(addrT a, logic expHit);
		doRequest(OP_READ, a, '0);
		expectEqual("read data", shadow[wordIndex(a)], gotData);
		expectEqual("hit", 32'(expHit), 32'(gotHit));
	endtask

	task automatic writeCheck(addrT a, wordT d, logic expHit);
		doRequest(OP_WRITE, a, d);
		shadow[wordIndex(a)] = d;
		expectEqual("hit", 32'(expHit), 32'(gotHit));
	endtask

	task automatic clearTraffic();
		readReqCount = 0;
		beatAddrs.delete();
		beatData.delete();
	endtask

	// whole line out in word order with requester data
	task automatic checkWriteback(int tag, int set);
		expectEqual("write-back beats", LINE_WORDS, beatAddrs.size());
		for (int k = 0; k < beatAddrs.size() && k < LINE_WORDS; k++) begin
			expectEqual("write-back address", lineAddr(tag, set, k), beatAddrs[k]);
			expectEqual("write-back data", shadow[wordIndex(lineAddr(tag, set, k))], beatData[k]);
		end
	endtask

	initial begin
		WATCHDOG: begin
			repeat (WATCHDOG_CYCLES) @(posedge clk);
			$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		op = OP_NONE;
		addr = '0;
		writeData = '0;
		checkCount = 0;
		errorCount = 0;
		readReqCount = 0;
		testName = "reset";
		repeat (5) @(negedge clk);
		reset = 1'b0;

		testName = "read miss";
		clearTraffic();
		readCheck(lineAddr(1, 3, 5), 1'b0);
		expectEqual("refill requests", 1, readReqCount);
		expectEqual("refill address", lineAddr(1, 3, 0), lastReadAddr);
		expectEqual("write beats", 0, beatAddrs.size());
		readCheck(lineAddr(1, 3, 2), 1'b1);
		expectEqual("refill requests", 1, readReqCount);

		testName = "write then read";
		writeCheck(lineAddr(1, 3, 2), 32'hCAFE0001, 1'b1);
		for (int w = 0; w < LINE_WORDS; w++) begin
			readCheck(lineAddr(1, 3, w), 1'b1);
		end
		writeCheck(lineAddr(2, 5, 4), 32'h5EED0002, 1'b0); // write miss allocates
		readCheck(lineAddr(2, 5, 4), 1'b1);

		testName = "lru";
		readCheck(lineAddr(1, 7, 0), 1'b0);
		readCheck(lineAddr(2, 7, 0), 1'b0);
		readCheck(lineAddr(1, 7, 1), 1'b1);
		readCheck(lineAddr(3, 7, 0), 1'b0); // B is older and leaves
		readCheck(lineAddr(1, 7, 2), 1'b1);
		readCheck(lineAddr(2, 7, 3), 1'b0);

		testName = "dirty eviction";
		writeCheck(lineAddr(1, 9, 3), 32'hD1D10003, 1'b0);
		writeCheck(lineAddr(1, 9, 6), 32'hD1D10006, 1'b1);
		readCheck(lineAddr(2, 9, 0), 1'b0);
		clearTraffic();
		readCheck(lineAddr(3, 9, 0), 1'b0);
		checkWriteback(1, 9);
		expectEqual("refill requests", 1, readReqCount);
		readCheck(lineAddr(1, 9, 3), 1'b0); // now served from memory
		readCheck(lineAddr(1, 9, 6), 1'b1);

		testName = "invalidate clean";
		readCheck(lineAddr(1, 11, 0), 1'b0);
		clearTraffic();
		doRequest(OP_INVALIDATE, lineAddr(1, 11, 0), '0);
		expectEqual("write beats", 0, beatAddrs.size());
		readCheck(lineAddr(1, 11, 4), 1'b0);

		testName = "invalidate dirty";
		writeCheck(lineAddr(2, 12, 1), 32'h0BAD0003, 1'b0);
		clearTraffic();
		doRequest(OP_INVALIDATE, lineAddr(2, 12, 5), '0);
		checkWriteback(2, 12);
		readCheck(lineAddr(2, 12, 1), 1'b0);

		testName = "invalidate absent";
		clearTraffic();
		doRequest(OP_INVALIDATE, lineAddr(5, 13, 0), '0);
		expectEqual("hit", 0, 32'(gotHit));
		expectEqual("refill requests", 0, readReqCount);
		expectEqual("write beats", 0, beatAddrs.size());

		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, dut0.sva0.failCount);
		if (errorCount == 0 && dut0.sva0.failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* src.f */
design/cacheGeomPkg.sv
design/cacheCtrlPkg.sv
design/lineBeatCounter.sv
design/tagStore.sv
design/dataStore.sv
design/cacheControl.sv
design/setAssocCache.sv
test/setAssocCache_sva.sv
test/setAssocCacheTb.sv

/* Makefile */
# Verilator build and run for the set-associative cache testbench

VERILATOR ?= verilator
TOP ?= setAssocCacheTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= >>> PASS
FAIL_MSG ?= >>> FAIL
COMMON_FLAGS ?= --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only
SIM_FLAGS ?= --binary --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '$(FAIL_MSG)' $(LOG) || ! grep -q -F '$(PASS_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
